// File: ok_host_pkg.sv
`default_nettype none

package ok_host_pkg;

	// ----------------------------------------
	// host words and control wire
	// ----------------------------------------
	typedef logic [31:0] word_t;	// one host or memory word

	// field order keeps the old wire-in bit numbers, op_en on bit 4
	typedef struct packed {
		logic op_en;		// route dma output to command/data fifos
		logic csb_reset;	// clear csb, command fifo and data fifo
		logic pipe_reset;	// clear pipe fifos and dma
		logic pipe_write;	// dma pulls blocks from pipe-in
		logic pipe_read;	// dma streams words out of memory
	} ctrl_word_t;

	typedef logic [10:0] count_t;	// fifo fill count, holds up to 2047

	// ----------------------------------------
	// sizing defaults for the top level
	// ----------------------------------------
	localparam int BLOCK_SIZE_DEF = 128;	// 512 byte block
	localparam int FIFO_DEPTH_DEF = 1023;
	localparam int HEADROOM_DEF   = 20;		// count lag plus words in flight
	localparam int MEM_WORDS_DEF  = 1024;

endpackage

`default_nettype wire

// File: csb_pkg.sv
`default_nettype none

package csb_pkg;

	// ----------------------------------------
	// operation encoding
	// ----------------------------------------
	typedef enum logic [2:0] {
		OP_CONV3   = 3'd0,	// 3x3 convolution
		OP_CONV1   = 3'd1,	// 1x1 convolution
		OP_MAXPOOL = 3'd2,
		OP_AVEPOOL = 3'd3
	} op_type_t;

	// ----------------------------------------
	// command word, msb first
	// ----------------------------------------
	typedef struct packed {
		op_type_t    op_type;			// bits 31:29
		logic [15:0] op_num;			// data words after the command
		logic [12:0] writeback_addr;	// result location, bits 12:0
	} cmd_t;

endpackage

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
	import ok_host_pkg::*;
#(
	parameter int  DEPTH     = FIFO_DEPTH_DEF,
	parameter type payload_t = word_t
) (
	input  logic     okClk,
	input  logic     rst,
	input  logic     clr,
	input  logic     wr,
	input  payload_t din,
	input  logic     rd,
	output payload_t dout,
	output logic     empty,
	output count_t   count
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          full;
	logic          do_wr;
	logic          do_rd;

	// depth need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == count_t'(DEPTH));
	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;
	assign dout  = mem[rd_ptr];	// show-ahead, head word always visible

	always_ff @(posedge okClk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge okClk) begin
		if (rst | clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// idle or write and read together
			endcase
		end
	end

	// ----------------------------------------
	// producer and consumer must honour the flags
	// ----------------------------------------
	a_no_overflow: assert property (@(posedge okClk) disable iff (rst || clr)
		!(wr && full))
		else $error("sync_fifo: write while full");

	a_no_underflow: assert property (@(posedge okClk) disable iff (rst || clr)
		!(rd && empty))
		else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// File: host_pipes.sv
`timescale 1ns/1ps
`default_nettype none

module host_pipes
	import ok_host_pkg::*;
#(
	parameter int BLOCK_SIZE = BLOCK_SIZE_DEF,
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF,
	parameter int HEADROOM   = HEADROOM_DEF
) (
	input  logic   okClk,
	input  logic   rst,
	input  logic   pipe_reset,
	input  logic   pi_write,
	input  word_t  pi_data,
	input  logic   in_rd,
	output word_t  in_data,
	output count_t in_count,
	input  logic   out_wr,
	input  word_t  out_data,
	output count_t out_count,
	input  logic   po_read,
	output word_t  po_data,
	output logic   pi_ready,
	output logic   po_ready
);

	localparam int PI_LIMIT = FIFO_DEPTH - HEADROOM - BLOCK_SIZE;	// room for one more block

	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(word_t)) u_pipe_in_fifo (
		.okClk (okClk),
		.rst   (rst),
		.clr   (pipe_reset),
		.wr    (pi_write),		// host strobe
		.din   (pi_data),
		.rd    (in_rd),			// dma block pop
		.dout  (in_data),
		.empty (),
		.count (in_count)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(word_t)) u_pipe_out_fifo (
		.okClk (okClk),
		.rst   (rst),
		.clr   (pipe_reset),
		.wr    (out_wr),		// steered dma word
		.din   (out_data),
		.rd    (po_read),		// host strobe
		.dout  (po_data),
		.empty (),
		.count (out_count)
	);

	// ----------------------------------------
	// block throttle, one cycle behind the counts
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (rst | pipe_reset) begin
			pi_ready <= 1'b0;
			po_ready <= 1'b0;
		end else begin
			pi_ready <= (in_count <= PI_LIMIT);
			po_ready <= (out_count >= BLOCK_SIZE);	// a whole block can be read
		end
	end

endmodule

`default_nettype wire

// File: dma.sv
`timescale 1ns/1ps
`default_nettype none

module dma
	import ok_host_pkg::*;
#(
	parameter int BLOCK_SIZE = BLOCK_SIZE_DEF,
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF,
	parameter int HEADROOM   = HEADROOM_DEF,
	parameter int MEM_WORDS  = MEM_WORDS_DEF
) (
	input  logic   okClk,
	input  logic   rst,
	input  logic   pipe_reset,
	input  logic   reads_en,
	input  logic   writes_en,
	output logic   ib_re,
	input  word_t  ib_data,
	input  count_t ib_count,
	output logic   ob_we,
	output word_t  ob_data,
	input  count_t ob_count
);

	localparam int AW       = $clog2(MEM_WORDS);
	localparam int BW       = $clog2(BLOCK_SIZE + 1);
	localparam int OB_LIMIT = FIFO_DEPTH - HEADROOM;	// leaves room for words in flight

	word_t         mem [MEM_WORDS];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   used;		// words written and not yet read
	logic [BW-1:0] blk_left;	// words still to move in this block
	logic          clr;
	logic          blk_start;
	logic          wr_fire;
	logic          rd_fire;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(MEM_WORDS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign clr = rst | pipe_reset;

	// ----------------------------------------
	// write side, whole blocks from pipe-in
	// ----------------------------------------
	assign blk_start = writes_en && (blk_left == '0)
		&& (ib_count >= BLOCK_SIZE)
		&& (int'(used) <= MEM_WORDS - BLOCK_SIZE);	// memory must take the block
	assign wr_fire = (blk_left != '0);
	assign ib_re   = wr_fire;	// one word per cycle until the block is done

	// ----------------------------------------
	// read side, word by word under ob_count
	// ----------------------------------------
	assign rd_fire = reads_en && (used != '0) && (ob_count <= OB_LIMIT);

	always_ff @(posedge okClk) begin
		if (wr_fire)
			mem[wr_ptr] <= ib_data;
		if (rd_fire)
			ob_data <= mem[rd_ptr];	// one cycle memory read
	end

	always_ff @(posedge okClk) begin
		if (clr) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			used     <= '0;
			blk_left <= '0;
			ob_we    <= 1'b0;	// drops any read in flight
		end else begin
			ob_we <= rd_fire;
			if (blk_start)
				blk_left <= BW'(BLOCK_SIZE);
			else if (wr_fire)
				blk_left <= blk_left - 1'b1;
			if (wr_fire)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_fire)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_fire, rd_fire})
				2'b10:   used <= used + 1'b1;
				2'b01:   used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	// unread words stay within the memory, neither pointer laps the other
	a_rd_trails_wr: assert property (@(posedge okClk) disable iff (clr)
		(used <= MEM_WORDS))
		else $error("dma: read and write pointers crossed");

endmodule

`default_nettype wire

// File: csb.sv
`timescale 1ns/1ps
`default_nettype none

module csb
	import csb_pkg::*;
(
	input  logic        okClk,
	input  logic        rst,
	input  logic        csb_reset,
	input  logic        op_en,
	input  cmd_t        cmd,
	input  logic        cmd_empty,
	input  logic        data_we,
	output logic        cmd_rd,
	output op_type_t    op_type,
	output logic [15:0] op_num,
	output logic [12:0] writeback_addr,
	output logic        op_run,
	output logic        irq
);

	logic [15:0] word_cnt;	// data words seen in this operation
	logic [15:0] cnt_next;
	logic        op_done;

	// ----------------------------------------
	// command pop
	// ----------------------------------------
	assign cmd_rd = op_en & ~op_run & ~cmd_empty;	// idle with a command waiting

	// ----------------------------------------
	// decode, fields held until the next pop
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (cmd_rd) begin
			op_type        <= cmd.op_type;
			op_num         <= cmd.op_num;
			writeback_addr <= cmd.writeback_addr;
		end
	end

	// ----------------------------------------
	// run tracking and interrupt
	// ----------------------------------------
	assign cnt_next = word_cnt + {15'd0, data_we};
	assign op_done  = op_run & (cnt_next >= op_num);	// zero length ends at once

	always_ff @(posedge okClk) begin
		if (rst | csb_reset) begin
			op_run   <= 1'b0;
			irq      <= 1'b0;
			word_cnt <= '0;
		end else begin
			irq <= op_done;	// single cycle pulse
			if (cmd_rd) begin
				op_run   <= 1'b1;
				// the word behind the command may land in the pop cycle
				word_cnt <= {15'd0, data_we};
			end else if (op_done) begin
				op_run <= 1'b0;
			end else if (op_run) begin
				word_cnt <= cnt_next;
			end
		end
	end

	a_cnt_in_range: assert property (@(posedge okClk) disable iff (rst || csb_reset)
		op_run |-> (word_cnt <= op_num))
		else $error("csb: more data words than the command announced");

endmodule

`default_nettype wire

// File: squeezenet_top.sv
`timescale 1ns/1ps
`default_nettype none

module squeezenet_top
	import ok_host_pkg::*;
	import csb_pkg::*;
#(
	parameter int BLOCK_SIZE = BLOCK_SIZE_DEF,
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF,
	parameter int HEADROOM   = HEADROOM_DEF,
	parameter int MEM_WORDS  = MEM_WORDS_DEF
) (
	input  logic        okClk,
	input  logic        rst,
	input  ctrl_word_t  ctrl,
	input  logic        pi_write,
	input  word_t       pi_data,
	output logic        pi_ready,
	input  logic        po_read,
	output word_t       po_data,
	output logic        po_ready,
	input  logic        data_rd,
	output word_t       data_dout,
	output logic        data_empty,
	output op_type_t    op_type,
	output logic [15:0] op_num,
	output logic        op_run,
	output logic        irq
);

	word_t  in_data;
	count_t in_count;
	logic   in_rd;
	count_t out_count;
	logic   out_wr;
	logic   dma_we;
	word_t  dma_data;
	count_t ob_count;
	logic   to_data;
	logic   to_cmd;
	logic   cmd_wr;
	logic   cmd_rd;
	logic   cmd_empty;
	cmd_t   cmd_q;
	count_t cmd_count;
	logic   data_wr;
	count_t data_count;

	host_pipes #(
		.BLOCK_SIZE (BLOCK_SIZE),
		.FIFO_DEPTH (FIFO_DEPTH),
		.HEADROOM   (HEADROOM)
	) u_host_pipes (
		.okClk      (okClk),
		.rst        (rst),
		.pipe_reset (ctrl.pipe_reset),
		.pi_write   (pi_write),
		.pi_data    (pi_data),
		.in_rd      (in_rd),
		.in_data    (in_data),
		.in_count   (in_count),
		.out_wr     (out_wr),
		.out_data   (dma_data),
		.out_count  (out_count),
		.po_read    (po_read),
		.po_data    (po_data),
		.pi_ready   (pi_ready),
		.po_ready   (po_ready)
	);

	dma #(
		.BLOCK_SIZE (BLOCK_SIZE),
		.FIFO_DEPTH (FIFO_DEPTH),
		.HEADROOM   (HEADROOM),
		.MEM_WORDS  (MEM_WORDS)
	) u_dma (
		.okClk      (okClk),
		.rst        (rst),
		.pipe_reset (ctrl.pipe_reset),
		.reads_en   (ctrl.pipe_read),
		.writes_en  (ctrl.pipe_write),
		.ib_re      (in_rd),
		.ib_data    (in_data),
		.ib_count   (in_count),
		.ob_we      (dma_we),
		.ob_data    (dma_data),
		.ob_count   (ob_count)
	);

	// ----------------------------------------
	// output steering and throttle count
	// ----------------------------------------
	// the pop cycle already belongs to the operation, so the word behind
	// a command goes to the data fifo
	assign to_data = ctrl.op_en & (op_run | cmd_rd);
	assign to_cmd  = ctrl.op_en & ~to_data;
	assign out_wr  = dma_we & ~ctrl.op_en;
	assign cmd_wr  = dma_we & to_cmd;
	assign data_wr = dma_we & to_data;

	always_comb begin
		if (!ctrl.op_en)
			ob_count = out_count;
		else if (to_data)
			ob_count = data_count;
		else
			ob_count = cmd_count;
	end

	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(cmd_t)) u_cmd_fifo (
		.okClk (okClk),
		.rst   (rst),
		.clr   (ctrl.csb_reset),
		.wr    (cmd_wr),
		.din   (cmd_t'(dma_data)),
		.rd    (cmd_rd),
		.dout  (cmd_q),
		.empty (cmd_empty),
		.count (cmd_count)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(word_t)) u_data_fifo (
		.okClk (okClk),
		.rst   (rst),
		.clr   (ctrl.csb_reset),
		.wr    (data_wr),
		.din   (dma_data),
		.rd    (data_rd),	// stands in for the engine
		.dout  (data_dout),
		.empty (data_empty),
		.count (data_count)
	);

	csb u_csb (
		.okClk          (okClk),
		.rst            (rst),
		.csb_reset      (ctrl.csb_reset),
		.op_en          (ctrl.op_en),
		.cmd            (cmd_q),
		.cmd_empty      (cmd_empty),
		.data_we        (data_wr),
		.cmd_rd         (cmd_rd),
		.op_type        (op_type),
		.op_num         (op_num),
		.writeback_addr (),		// no writeback path here
		.op_run         (op_run),
		.irq            (irq)
	);

endmodule

`default_nettype wire

// File: tb_squeezenet_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_squeezenet_top
	import ok_host_pkg::*;
	import csb_pkg::*;
();

	localparam int BLOCK    = 16;
	localparam int DEPTH    = 63;
	localparam int ROOM     = 4;
	localparam int WORDS    = 64;
	localparam int PI_LIMIT = DEPTH - ROOM - BLOCK;	// 43 words still leave room for a block
	localparam int TIMEOUT  = 2000;					// cycles per wait
	localparam int N_TESTS  = 5;

	typedef struct packed {
		logic [127:0] name;		// up to 16 characters
		logic         op_en;
		op_type_t     op_type;	// type of the first command
		logic [3:0]   blocks;
		logic         pulse_reset;
	} test_row_t;

	logic         okClk = 1'b0;
	logic         rst;
	ctrl_word_t   ctrl;
	logic         pi_write;
	word_t        pi_data;
	logic         pi_ready;
	logic         po_read;
	word_t        po_data;
	logic         po_ready;
	logic         data_rd;
	word_t        data_dout;
	logic         data_empty;
	op_type_t     op_type;
	logic [15:0]  op_num;
	logic         op_run;
	logic         irq;

	test_row_t    tests [N_TESTS];
	logic [127:0] cur_name;
	word_t        exp_q [$];	// words expected back, in order
	int           errors   = 0;
	int           timeouts = 0;
	int           irq_seen = 0;

	squeezenet_top #(
		.BLOCK_SIZE (BLOCK),
		.FIFO_DEPTH (DEPTH),
		.HEADROOM   (ROOM),
		.MEM_WORDS  (WORDS)
	) u_squeezenet_top (
		.okClk      (okClk),
		.rst        (rst),
		.ctrl       (ctrl),
		.pi_write   (pi_write),
		.pi_data    (pi_data),
		.pi_ready   (pi_ready),
		.po_read    (po_read),
		.po_data    (po_data),
		.po_ready   (po_ready),
		.data_rd    (data_rd),
		.data_dout  (data_dout),
		.data_empty (data_empty),
		.op_type    (op_type),
		.op_num     (op_num),
		.op_run     (op_run),
		.irq        (irq)
	);

	always #4 okClk = ~okClk;

	always @(negedge okClk) begin
		if (irq === 1'b1)
			irq_seen++;	// one count per pulse cycle
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic test_row_t make_row(input logic [127:0] name, input logic op_en,
		input op_type_t op, input int blocks, input logic pulse);
		test_row_t r;
		r.name        = name;
		r.op_en       = op_en;
		r.op_type     = op;
		r.blocks      = 4'(blocks);
		r.pulse_reset = pulse;
		return r;
	endfunction

	task automatic step();
		@(posedge okClk);
		#1;	// inputs change just after the edge
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR %0s %0s: expected %0h, actual %0h", cur_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic set_ctrl(input logic op_en, input logic wr_en, input logic rd_en);
		ctrl            = '0;
		ctrl.op_en      = op_en;
		ctrl.pipe_write = wr_en;
		ctrl.pipe_read  = rd_en;
	endtask

	task automatic wait_pi_ready();
		int n;
		n = 0;
		while (!pi_ready && n < TIMEOUT) begin
			step();
			n++;
		end
		assert (pi_ready) else begin
			$display("%0s: pi_ready never came back high", cur_name);
			timeouts++;
		end
	endtask

	// a command word, when given, goes first and is not expected back
	task automatic push_words(input int n, input logic with_cmd, input cmd_t cmd,
		input logic keep);
		word_t w;
		wait_pi_ready();
		for (int i = 0; i < n; i++) begin
			w = (with_cmd && i == 0) ? word_t'(cmd) : word_t'($urandom());
			if (keep && !(with_cmd && i == 0))
				exp_q.push_back(w);
			pi_write = 1'b1;
			pi_data  = w;
			step();
		end
		pi_write = 1'b0;
	endtask

	task automatic read_pipe_out(input int n);
		int t;
		t = 0;
		while (!po_ready && t < TIMEOUT) begin
			step();
			t++;
		end
		assert (po_ready) else begin
			$display("%0s: pipe-out never signalled a full block", cur_name);
			timeouts++;
		end
		if (po_ready) begin
			// a raised po_ready covers the whole block
			for (int i = 0; i < n; i++) begin
				check_value("po_data", (exp_q.size() != 0) ? exp_q.pop_front() : 32'hx,
					po_data);
				po_read = 1'b1;
				step();
			end
		end
		po_read = 1'b0;
		step();	// lets po_ready catch up with the pops
	endtask

	task automatic read_data_port(input int n);
		int got;
		int t;
		got = 0;
		t   = 0;
		while (got < n && t < TIMEOUT) begin
			data_rd = 1'b0;
			if (!data_empty) begin
				check_value("data_dout", (exp_q.size() != 0) ? exp_q.pop_front() : 32'hx,
					data_dout);
				data_rd = 1'b1;
				got++;
			end
			step();
			t++;
		end
		data_rd = 1'b0;
		assert (got == n) else begin
			$display("%0s: data port gave %0d of %0d words", cur_name, got, n);
			timeouts++;
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic run_loopback(input int blocks);
		set_ctrl(1'b0, 1'b1, 1'b1);
		for (int b = 0; b < blocks; b++)
			push_words(BLOCK, 1'b0, '0, 1'b1);
		for (int b = 0; b < blocks; b++)
			read_pipe_out(BLOCK);
		check_value("words left", 0, exp_q.size());
	endtask

	task automatic run_throttle();
		set_ctrl(1'b0, 1'b0, 1'b0);	// nothing drains pipe-in
		for (int k = 1; k <= PI_LIMIT + 1; k++) begin
			pi_write = 1'b1;
			pi_data  = $urandom();
			step();
			pi_write = 1'b0;
			step();
			check_value("pi_ready", (k <= PI_LIMIT), pi_ready);
		end
		ctrl.pipe_reset = 1'b1;	// empty pipe-in for the next test
		step();
		ctrl.pipe_reset = 1'b0;
		wait_pi_ready();
	endtask

	task automatic run_ops(input test_row_t row);
		cmd_t cmd;
		int   irq_start;
		irq_start = irq_seen;
		set_ctrl(1'b1, 1'b1, 1'b1);
		for (int b = 0; b < row.blocks; b++) begin
			cmd.op_type        = op_type_t'(3'((int'(row.op_type) + b) % 4));
			cmd.op_num         = 16'(BLOCK - 1);
			cmd.writeback_addr = 13'($urandom());
			push_words(BLOCK, 1'b1, cmd, 1'b1);
		end
		read_data_port((BLOCK - 1) * row.blocks);
		for (int t = 0; t < TIMEOUT && op_run; t++)
			step();
		step();
		step();
		check_value("irq pulses", row.blocks, irq_seen - irq_start);
		check_value("op_type", cmd.op_type, op_type);
		check_value("op_num", cmd.op_num, op_num);
		check_value("op_run", 0, op_run);
		check_value("data_empty", 1, data_empty);
	endtask

	task automatic run_pipe_reset();
		set_ctrl(1'b0, 1'b1, 1'b1);
		push_words(10, 1'b0, '0, 1'b0);	// partial block, must vanish
		step();
		ctrl.pipe_reset = 1'b1;
		step();
		ctrl.pipe_reset = 1'b0;
		for (int i = 0; i < 6; i++) begin
			step();
			check_value("po_ready", 0, po_ready);
		end
		wait_pi_ready();
		push_words(BLOCK, 1'b0, '0, 1'b1);
		read_pipe_out(BLOCK);
		step();
		check_value("po_ready", 0, po_ready);
		check_value("words left", 0, exp_q.size());
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		rst      = 1'b1;
		ctrl     = '0;
		pi_write = 1'b0;
		pi_data  = '0;
		po_read  = 1'b0;
		data_rd  = 1'b0;
		cur_name = "reset";
		void'($urandom(32'h1536_e66e));
		tests[0] = make_row("loopback", 1'b0, OP_CONV3, 2, 1'b0);
		tests[1] = make_row("throttle", 1'b0, OP_CONV3, 0, 1'b0);
		tests[2] = make_row("cmd_decode", 1'b1, OP_MAXPOOL, 1, 1'b0);
		tests[3] = make_row("back_to_back", 1'b1, OP_CONV1, 2, 1'b0);
		tests[4] = make_row("pipe_reset", 1'b0, OP_CONV3, 1, 1'b1);
		repeat (3) @(posedge okClk);
		#1 rst = 1'b0;
		check_value("pi_ready", 0, pi_ready);
		check_value("po_ready", 0, po_ready);
		check_value("op_run", 0, op_run);
		check_value("irq", 0, irq);
		step();
		check_value("pi_ready", 1, pi_ready);	// rises one cycle after reset
		for (int i = 0; i < N_TESTS && timeouts == 0; i++) begin
			cur_name = tests[i].name;
			exp_q.delete();
			if (tests[i].pulse_reset)
				run_pipe_reset();
			else if (tests[i].blocks == 0)
				run_throttle();
			else if (tests[i].op_en)
				run_ops(tests[i]);
			else
				run_loopback(tests[i].blocks);
			step();
		end
		$display("checks done: %0d value errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
ok_host_pkg.sv
csb_pkg.sv
sync_fifo.sv
host_pipes.sv
dma.sv
csb.sv
squeezenet_top.sv
tb_squeezenet_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_squeezenet_top -o tb_squeezenet_top
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/tb_squeezenet_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
